/* verilog/mcpu_consts.svh */
`ifndef MCPU_CONSTS_SVH
`define MCPU_CONSTS_SVH

// ltc2mc port widths, same as the DDR controller port
`define MCPU_ADDR_W       25
`define MCPU_DATA_W       128
`define MCPU_BE_W         16   // One enable per data byte
`define MCPU_SIZE_W       5

// Word layout used by the control engine
`define MCPU_LANE_W       32
`define MCPU_LANES        4

// Model store
`define MCPU_WORDS        32
`define MCPU_WORD_AW      5    // Index bits into the store
`define MCPU_INIT_CYCLES  32   // One word cleared per cycle

// Queue depths
`define MCPU_CMD_DEPTH    4    // Request queue inside the controller
`define MCPU_OP_DEPTH     4    // Button operation queue

// Board pins
`define MCPU_SW_W         10
`define MCPU_BTN_W        4
`define MCPU_SEED_W       5

`endif

/* verilog/mcpu_avl_pkg.sv */
`include "mcpu_consts.svh"

package mcpu_avl_pkg;

  // One command on the ltc2mc port
  typedef struct packed {
    logic                    read;        // Level request, held until ready
    logic                    write;
    logic [`MCPU_ADDR_W-1:0] addr;        // Word address
    logic [`MCPU_BE_W-1:0]   be;          // Byte lane enables
    logic [`MCPU_DATA_W-1:0] wdata;
    logic [`MCPU_SIZE_W-1:0] size;        // Burst length in beats
    logic                    burstbegin;  // First beat of a burst
  } avl_req_t;

  // Read return path
  typedef struct packed {
    logic [`MCPU_DATA_W-1:0] rdata;
    logic                    rdata_valid; // Single cycle pulse
  } avl_rsp_t;

endpackage

/* verilog/mcpu_board_pkg.sv */
`include "mcpu_consts.svh"

package mcpu_board_pkg;

  // Board inputs, buttons already active high
  typedef struct packed {
    logic [`MCPU_SW_W-1:0]  sw;
    logic [`MCPU_BTN_W-1:0] btn;
  } board_in_t;

  // Queued button operation
  typedef struct packed {
    logic                     wr;    // 1 write, 0 read
    logic [`MCPU_WORD_AW-1:0] addr;  // Store word
    logic [`MCPU_SEED_W-1:0]  seed;  // Low half of lane pattern
  } board_cmd_t;

endpackage

/* verilog/mcpu_reset.sv */
`timescale 1ns/10ps

module mcpu_reset (
  input  logic clk50,
  input  logic rst_n,       // Board reset
  input  logic key0_n,      // User reset button, low when pressed
  input  logic mc_ready,    // Memory init finished
  output logic mem_rst_n,
  output logic core_rst_n
);

  logic [1:0] mem_sync;
  logic [1:0] core_sync;
  logic       core_arst_n;

  // Memory domain follows the board reset only
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      mem_sync <= 2'b00;
    end else begin
      mem_sync <= {mem_sync[0], 1'b1};
    end
  end

  assign mem_rst_n = mem_sync[1];

  // Core held off until memory is up and button 0 released
  assign core_arst_n = mem_rst_n & mc_ready & key0_n;

  always_ff @(posedge clk50 or negedge core_arst_n) begin
    if (!core_arst_n) begin
      core_sync <= 2'b00;
    end else begin
      core_sync <= {core_sync[0], 1'b1}; // Two clock release
    end
  end

  assign core_rst_n = core_sync[1];

  // Core must never run while memory side is in reset
  a_core_after_mem: assert property (@(posedge clk50) !mem_rst_n |-> !core_rst_n)
    else $error("core_rst_n released while mem_rst_n low");

endmodule

/* verilog/mcpu_req_fifo.sv */
`timescale 1ns/10ps

module mcpu_req_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk50,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,   // Head entry, valid when not empty
  output logic     full,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_push;
  logic               do_pop;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  assign do_push = push & ~full;   // Overflow ignored
  assign do_pop  = pop & ~empty;

  // Pointers and occupancy
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk50) begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  assign pop_data = mem[rd_ptr];   // Show-ahead read

  a_no_overflow: assert property (@(posedge clk50) disable iff (!rst_n) !(push && full))
    else $error("FIFO push while full");

  a_no_underflow: assert property (@(posedge clk50) disable iff (!rst_n) !(pop && empty))
    else $error("FIFO pop while empty");

endmodule

/* verilog/mcpu_ctl.sv */
`timescale 1ns/10ps
`include "mcpu_consts.svh"

module mcpu_ctl (
  input  logic                      clk50,
  input  logic                      rst_n,    // Core reset
  input  mcpu_board_pkg::board_in_t board,
  output mcpu_avl_pkg::avl_req_t    req,
  input  logic                      ready,
  input  mcpu_avl_pkg::avl_rsp_t    rsp,
  output logic [9:0]                led_r,
  output logic [6:0]                led_g
);

  import mcpu_board_pkg::*;

  localparam int LANE_W = `MCPU_LANE_W;
  localparam int LANES  = `MCPU_LANES;

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_t;

  state_t                  state;
  logic [3:1]              btn_s1;
  logic [3:1]              btn_s2;
  logic [3:1]              btn_d;
  logic [3:1]              btn_rise;
  board_cmd_t              push_cmd;
  board_cmd_t              head_cmd;
  board_cmd_t              cur;         // Operation in flight
  logic                    op_push;
  logic                    op_pop;
  logic                    op_full;
  logic                    op_empty;
  logic [9:0]              lane_base;
  logic [`MCPU_DATA_W-1:0] wdata;
  logic                    rd_done;
  logic                    rd_mismatch;
  logic                    mismatch;
  logic [3:0]              rd_count;

  // Button sync and rise detect
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      btn_s1 <= '0;
      btn_s2 <= '0;
      btn_d  <= '0;
    end else begin
      btn_s1 <= board.btn[3:1];
      btn_s2 <= btn_s1;
      btn_d  <= btn_s2;
    end
  end

  assign btn_rise = btn_s2 & ~btn_d;

  // Switches become the command, write wins over read
  assign push_cmd.wr   = btn_rise[1];
  assign push_cmd.addr = board.sw[9:5];
  assign push_cmd.seed = board.sw[4:0];
  assign op_push       = (btn_rise[1] | btn_rise[2]) & ~op_full;  // Drop when full

  mcpu_req_fifo #(
    .payload_t (board_cmd_t),
    .DEPTH     (`MCPU_OP_DEPTH)
  ) u_op_fifo (
    .clk50     (clk50),
    .rst_n     (rst_n),
    .push      (op_push),
    .push_data (push_cmd),
    .pop       (op_pop),
    .pop_data  (head_cmd),
    .full      (op_full),
    .empty     (op_empty)
  );

  // One operation outstanding at a time
  assign op_pop = (state == S_IDLE) & ~op_empty;

  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (op_pop) state <= S_REQ;
        S_REQ:   if (ready) state <= cur.wr ? S_IDLE : S_WAIT;  // Writes end on accept
        S_WAIT:  if (rsp.rdata_valid) state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk50) begin
    if (op_pop)
      cur <= head_cmd;
  end

  // Lane k carries base plus k
  assign lane_base = {cur.addr, cur.seed};

  always_comb begin
    for (int k = 0; k < LANES; k++)
      wdata[k*LANE_W +: LANE_W] = LANE_W'(lane_base + 10'(k));
  end

  // Request held steady through S_REQ
  assign req.read       = (state == S_REQ) & ~cur.wr;
  assign req.write      = (state == S_REQ) & cur.wr;
  assign req.addr       = `MCPU_ADDR_W'(cur.addr);
  assign req.be         = '1;                     // Full word only
  assign req.wdata      = wdata;
  assign req.size       = `MCPU_SIZE_W'(1);       // Single beat
  assign req.burstbegin = (state == S_REQ);

  assign rd_done = (state == S_WAIT) & rsp.rdata_valid;

  // Check remaining lanes against lane 0
  always_comb begin
    rd_mismatch = 1'b0;
    for (int k = 1; k < LANES; k++) begin
      if (rsp.rdata[k*LANE_W +: LANE_W] != LANE_W'(rsp.rdata[9:0] + 10'(k)))
        rd_mismatch = 1'b1;
    end
  end

  // Result display, button 3 clears
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      led_r    <= '0;
      mismatch <= 1'b0;
      rd_count <= '0;
    end else if (btn_rise[3]) begin
      led_r    <= '0;
      mismatch <= 1'b0;
      rd_count <= '0;
    end else if (rd_done) begin
      led_r    <= rsp.rdata[9:0];    // Lane 0 low bits
      mismatch <= rd_mismatch;       // Reflects the last read
      rd_count <= rd_count + 1'b1;   // Wraps at 16
    end
  end

  assign led_g[6]   = (state != S_IDLE);  // Busy
  assign led_g[5]   = op_full;            // Presses being dropped
  assign led_g[4]   = mismatch;
  assign led_g[3:0] = rd_count;

  a_one_dir: assert property (@(posedge clk50) disable iff (!rst_n) !(req.read && req.write))
    else $error("read and write requested together");

endmodule

/* verilog/mcpu_mc.sv */
`timescale 1ns/10ps
`include "mcpu_consts.svh"

module mcpu_mc (
  input  logic                   clk50,
  input  logic                   rst_n,     // Memory reset
  input  mcpu_avl_pkg::avl_req_t req,
  output logic                   ready,
  output mcpu_avl_pkg::avl_rsp_t rsp,
  output logic                   mc_ready
);

  import mcpu_avl_pkg::*;

  localparam int INIT_W  = $clog2(`MCPU_INIT_CYCLES + 1);
  localparam int WORD_AW = `MCPU_WORD_AW;

  logic [`MCPU_DATA_W-1:0] store [`MCPU_WORDS];
  logic [INIT_W-1:0]       init_cnt;
  logic                    init_done;
  logic [7:0]              lfsr;
  logic                    gate;
  logic                    accept;
  logic                    q_full;
  logic                    q_empty;
  logic                    exec;
  avl_req_t                head;
  logic [WORD_AW-1:0]      head_idx;
  logic [`MCPU_DATA_W-1:0] merged;
  logic [`MCPU_DATA_W-1:0] rdata_q;
  logic                    rvalid_q;

  // Init phase walks the store once
  assign init_done = (init_cnt == INIT_W'(`MCPU_INIT_CYCLES));

  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      init_cnt <= '0;
      mc_ready <= 1'b0;
    end else begin
      if (!init_done)
        init_cnt <= init_cnt + 1'b1;
      mc_ready <= init_done;   // One clock after last clear
    end
  end

  // Pacing gate, roughly every other cycle
  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= 8'hA5;
    end else begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  assign gate = lfsr[0];

  // Request acceptance
  assign ready  = mc_ready & ~q_full;
  assign accept = (req.read | req.write) & ready;

  mcpu_req_fifo #(
    .payload_t (avl_req_t),
    .DEPTH     (`MCPU_CMD_DEPTH)
  ) u_cmd_fifo (
    .clk50     (clk50),
    .rst_n     (rst_n),
    .push      (accept),
    .push_data (req),
    .pop       (exec),
    .pop_data  (head),
    .full      (q_full),
    .empty     (q_empty)
  );

  assign exec     = mc_ready & gate & ~q_empty;
  assign head_idx = head.addr[WORD_AW-1:0];   // Upper address bits ignored

  // Byte merge for writes
  always_comb begin
    for (int b = 0; b < `MCPU_BE_W; b++)
      merged[b*8 +: 8] = head.be[b] ? head.wdata[b*8 +: 8] : store[head_idx][b*8 +: 8];
  end

  always_ff @(posedge clk50) begin
    if (!init_done)
      store[init_cnt[WORD_AW-1:0]] <= '0;   // Clear during init
    else if (exec && head.write)
      store[head_idx] <= merged;
  end

  // Read return
  always_ff @(posedge clk50) begin
    if (exec && head.read)
      rdata_q <= store[head_idx];
  end

  always_ff @(posedge clk50 or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= exec & head.read;   // No response for writes
    end
  end

  assign rsp.rdata       = rdata_q;
  assign rsp.rdata_valid = rvalid_q;

  // Core side must stay quiet until memory init completes
  a_req_after_ready: assert property (@(posedge clk50) disable iff (!rst_n)
    (req.read || req.write) |-> mc_ready)
    else $error("request raised before mc_ready");

endmodule

/* verilog/mcpu.sv */
`timescale 1ns/10ps
`include "mcpu_consts.svh"

module mcpu (
  input  logic                   clk50,
  input  logic                   rst_n,
  input  logic [`MCPU_SW_W-1:0]  SW,
  input  logic [`MCPU_BTN_W-1:0] KEY,    // Active low
  output logic [9:0]             LEDR,
  output logic [7:0]             LEDG
);

  import mcpu_board_pkg::*;
  import mcpu_avl_pkg::*;

  board_in_t  board;
  avl_req_t   ltc2mc_req;
  avl_rsp_t   ltc2mc_rsp;
  logic       ltc2mc_ready;
  logic       mc_ready;
  logic       mem_rst_n;
  logic       core_rst_n;
  logic [6:0] led_g;

  assign board.sw  = SW;
  assign board.btn = ~KEY;              // Buttons active high inside
  assign LEDG      = {mc_ready, led_g}; // Top green LED shows memory ready

  mcpu_reset u_reset (
    .clk50      (clk50),
    .rst_n      (rst_n),
    .key0_n     (KEY[0]),
    .mc_ready   (mc_ready),
    .mem_rst_n  (mem_rst_n),
    .core_rst_n (core_rst_n)
  );

  mcpu_ctl u_ctl (
    .clk50 (clk50),
    .rst_n (core_rst_n),
    .board (board),
    .req   (ltc2mc_req),
    .ready (ltc2mc_ready),
    .rsp   (ltc2mc_rsp),
    .led_r (LEDR),
    .led_g (led_g)
  );

  mcpu_mc u_mc (
    .clk50    (clk50),
    .rst_n    (mem_rst_n),
    .req      (ltc2mc_req),
    .ready    (ltc2mc_ready),
    .rsp      (ltc2mc_rsp),
    .mc_ready (mc_ready)
  );

endmodule

/* bench/mcpu_tb.sv */
`timescale 1ns/10ps
`include "mcpu_consts.svh"

module mcpu_tb;

  localparam int PERIOD    = 40;
  localparam int DRIVE_DLY = 2;    // Inputs change this long after the rising edge
  localparam int WAIT_MAX  = 200;  // Cycle limit for any single wait

  logic       clk50;
  logic       rst_n;
  logic [9:0] sw;
  logic [3:0] key;                 // Active low as on the board
  logic [9:0] ledr;
  logic [7:0] ledg;

  int         fd;
  int         errors;
  int         tests;
  int         failed_tests;
  bit         aborted;             // Stops the vector loop after a hard failure

  mcpu uut (
    .clk50 (clk50),
    .rst_n (rst_n),
    .SW    (sw),
    .KEY   (key),
    .LEDR  (ledr),
    .LEDG  (ledg)
  );

  initial begin
    clk50 = 1'b0;
    forever #(PERIOD / 2) clk50 = ~clk50;
  end

  // Drive point of the next cycle where outputs have settled
  task automatic next_cycle();
    @(posedge clk50);
    #(DRIVE_DLY);
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("Fail at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_leds(input int led, input int flag, input int cnt);
    check_val("LEDR", int'(ledr), led);
    check_val("LEDG[4] mismatch", int'(ledg[4]), flag);
    check_val("LEDG[3:0] read count", int'(ledg[3:0]), cnt);
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0d ns: %s did not happen within %0d cycles", $time, what, WAIT_MAX);
    errors++;
    aborted = 1'b1;
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors != err_before)
      failed_tests++;
    $display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "fail");
  endtask

  // Button down three cycles then up two without waiting on the DUT
  task automatic press(input int btn);
    key[btn] = 1'b0;
    repeat (3) next_cycle();
    key[btn] = 1'b1;
    repeat (2) next_cycle();
  endtask

  // Single operation done when busy has come and gone
  task automatic run_op(input bit is_read);
    int         cycles;
    int         btn;
    bit         seen_busy;
    logic [3:0] old_cnt;
    btn       = is_read ? 2 : 1;
    old_cnt   = ledg[3:0];
    seen_busy = 1'b0;
    cycles    = 0;
    key[btn]  = 1'b0;
    while (!(seen_busy && !ledg[6] && (!is_read || ledg[3:0] != old_cnt))
           && cycles < WAIT_MAX) begin
      next_cycle();
      cycles++;
      if (cycles == 3)
        key[btn] = 1'b1;               // Release since the press is queued by now
      if (ledg[6])
        seen_busy = 1'b1;
    end
    key[btn] = 1'b1;
    if (cycles >= WAIT_MAX)
      report_timeout(is_read ? "read completion" : "write completion");
  endtask

  // Engine idle with the given read count
  task automatic wait_count(input int cnt);
    int cycles;
    cycles = 0;
    while ((ledg[3:0] != cnt[3:0] || ledg[6]) && cycles < WAIT_MAX) begin
      next_cycle();
      cycles++;
    end
    if (cycles >= WAIT_MAX)
      report_timeout("idle engine with expected read count");
  endtask

  // Core side reset while memory stays up
  task automatic hold_core_reset(input int led, input int flag, input int cnt);
    key[0] = 1'b0;
    repeat (8) next_cycle();
    check_leds(led, flag, cnt);
    check_val("LEDG[6] busy", int'(ledg[6]), 0);
    check_val("LEDG[7] mc_ready", int'(ledg[7]), 1);
    key[0] = 1'b1;
    repeat (3) next_cycle();           // Core reset releases two clocks later
  endtask

  initial begin
    logic [7:0] op;
    int         n;
    int         c;
    int         addr;
    int         seed;
    int         exp_led;
    int         exp_flag;
    int         exp_cnt;
    int         gap;
    int         cycles;
    int         err_before;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    aborted      = 1'b0;
    fd           = 0;
    rst_n        = 1'b0;
    sw           = '0;
    key          = 4'hF;               // No button pressed
    void'($urandom(95345));
    repeat (8) next_cycle();
    rst_n = 1'b1;

    // Reset and memory init
    err_before = errors;
    cycles     = 0;
    while (!ledg[7] && cycles < WAIT_MAX) begin
      next_cycle();
      cycles++;
    end
    if (!ledg[7]) begin
      report_timeout("LEDG[7] memory ready");
    end else begin
      // Two release flops then the init length plus one
      check_val("LEDG[7] rise cycle", cycles, `MCPU_INIT_CYCLES + 3);
    end
    check_val("LEDR", int'(ledr), 0);
    check_val("LEDG[5:0]", int'(ledg[5:0]), 0);
    repeat (3) next_cycle();           // Core reset release
    end_test("reset and memory init", err_before);

    fd = $fopen("bench/mcpu_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/mcpu_vectors.txt");
      errors++;
      aborted = 1'b1;
    end

    while (!aborted) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1)
        break;                         // End of file
      if (op == "#") begin
        c = $fgetc(fd);
        while (c != 10 && c != -1)
          c = $fgetc(fd);
        continue;
      end
      n = $fscanf(fd, "%d %d %h %d %d", addr, seed, exp_led, exp_flag, exp_cnt);
      if (n != 5) begin
        $display("Vector line for op %c has %0d of 5 fields", op, n);
        errors++;
        aborted = 1'b1;
        continue;
      end
      err_before = errors;
      sw = {addr[4:0], seed[4:0]};     // Address in the high bits and seed low
      if (op != "w" && op != "r" && op != "D") begin
        gap = $urandom % 6;            // Idle gap but none inside a burst
        repeat (gap) next_cycle();
      end
      case (op)
        "W": run_op(1'b0);
        "R": run_op(1'b1);
        "w": press(1);                 // Queued behind the busy engine
        "r": press(2);
        "D": wait_count(exp_cnt);
        "C": begin
          press(3);
          wait_count(exp_cnt);
        end
        "K": hold_core_reset(exp_led, exp_flag, exp_cnt);
        default: begin
          $display("Unknown op %c in the vector file", op);
          errors++;
          aborted = 1'b1;
        end
      endcase
      if (op != "w" && op != "r") begin
        if (!aborted)
          check_leds(exp_led, exp_flag, exp_cnt);
        end_test($sformatf("op %c addr %0d seed %0d", op, addr, seed), err_before);
      end
    end

    if (fd != 0)
      $fclose(fd);
    $display("%0d tests run, %0d failed, %0d check errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Guard against a run that never reaches the report
  initial begin
    #(PERIOD * 10000);
    $display("Simulation ran past its time limit");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* bench/mcpu_vectors.txt */
# op addr seed led_hex flag count : expected LEDR, LEDG[4], LEDG[3:0] after the op
# W/R press and wait, w/r queue a press only (not checked), D wait count, C clear, K hold KEY[0]
R 7 0 000 1 1
W 3 17 000 1 1
R 3 0 071 0 2
W 20 5 071 0 2
R 20 0 285 0 3
W 3 30 285 0 3
R 3 0 07e 0 4
W 31 31 07e 0 4
R 31 0 3ff 0 5
R 0 0 000 1 6
C 0 0 000 0 0
w 10 1 000 0 0
w 11 2 000 0 0
r 7 0 000 0 0
r 10 0 000 0 0
r 11 0 000 0 0
D 0 0 162 0 3
K 0 0 000 0 0
R 11 0 162 0 1
R 20 0 285 0 2
R 3 0 07e 0 3
R 31 0 3ff 0 4
C 0 0 000 0 0

/* sources.f */
+incdir+verilog
verilog/mcpu_avl_pkg.sv
verilog/mcpu_board_pkg.sv
verilog/mcpu_reset.sv
verilog/mcpu_req_fifo.sv
verilog/mcpu_ctl.sv
verilog/mcpu_mc.sv
verilog/mcpu.sv
bench/mcpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module mcpu_tb -o mcpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mcpu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi
echo "Simulation finished without failures"
exit 0
